// File: rv_core_pkg.sv
/*
  RV32I execution core shared definitions
  Widths, major opcodes, ALU operation codes and the decoded instruction
*/
`default_nettype none

package rv_core_pkg;

  // Datapath width, RV32 only
  localparam int unsigned XLEN = 32;

  // Register index width as encoded in the instruction
  localparam int unsigned REG_ADDR_W = 5;

  // Major opcodes handled by the execution unit
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // ALU operation select
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    // Operand B straight through, used by LUI
    ALU_PASSB
  } alu_op_e;

  // Decoded instruction as seen by register file, ALU and writeback
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    // Sign-extended I-type or upper U-type immediate
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
    // Operand B from the immediate instead of rs2
    logic                  use_imm;
    logic                  writes_rd;
  } dec_instr_t;

endpackage

`default_nettype wire

// File: rv_dec_if.sv
/*
  Decoded instruction bundle
  Carries valid, decoded fields and the illegal flag from the decoder
*/
`timescale 1ns/1ps
`default_nettype none

interface rv_dec_if;
  import rv_core_pkg::*;

  // High for one cycle per legal instruction
  logic       valid;
  dec_instr_t instr;
  // High for one cycle per rejected instruction
  logic       illegal;

  // Decoder side
  modport dec (
    output valid,
    output instr,
    output illegal
  );

  // Execute side: ALU, writeback and top level
  modport exe (
    input valid,
    input instr,
    input illegal
  );

endinterface

`default_nettype wire

// File: rv_regfile_fpga.sv
/*
  Integer register file for RAM inference
  Two asynchronous read ports, one synchronous write port, x0 reads zero
*/
`timescale 1ns/1ps
`default_nettype none

module rv_regfile_fpga #(
  parameter bit                              RV32E       = 1'b0,
  parameter logic [rv_core_pkg::XLEN-1:0]    WordZeroVal = '0
) (
  input  logic                               clk_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_b_o,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv_core_pkg::XLEN-1:0]       wdata_i,
  input  logic                               we_i
);
  import rv_core_pkg::*;

  // 16 entries for RV32E, 32 otherwise
  localparam int unsigned AddrW    = RV32E ? 4 : 5;
  localparam int unsigned NumWords = 2 ** AddrW;

  logic [XLEN-1:0] mem [NumWords];
  // Write strobe with x0 masked out
  logic            we;

  // Combinational reads, index zero is hardwired
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem[raddr_a_i[AddrW-1:0]];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem[raddr_b_i[AddrW-1:0]];

  assign we = we_i && (waddr_i != '0);

  always @(posedge clk_i) begin
    if (we) begin
      mem[waddr_i[AddrW-1:0]] <= wdata_i;
    end
  end

  // Power-up contents for the inferred RAM
  initial begin
    for (int k = 0; k < NumWords; k++) begin
      mem[k] = WordZeroVal;
    end
  end

  // Decoder must have rejected upper indices before they reach the write port
  a_rv32e_waddr: assert property (@(posedge clk_i) we_i |-> !(RV32E && waddr_i[4]))
    else $error("RV32E write to register index %0d", waddr_i);

endmodule

`default_nettype wire

// File: rv_decoder.sv
/*
  RV32I instruction decoder
  OP, OP-IMM and LUI into indices, immediate, ALU op and legality
*/
`timescale 1ns/1ps
`default_nettype none

module rv_decoder #(
  parameter bit RV32E = 1'b0
) (
  input  logic                         instr_valid_i,
  input  logic [rv_core_pkg::XLEN-1:0] instr_i,
  rv_dec_if.dec                        dec_o
);
  import rv_core_pkg::*;

  // funct7 encodings
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rs1_idx;
  logic [REG_ADDR_W-1:0] rs2_idx;
  logic [REG_ADDR_W-1:0] rd_idx;
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic                  bad_enc;
  logic                  bad_idx;
  logic                  illegal;
  dec_instr_t            instr_d;

  // Fixed instruction fields
  assign opcode  = instr_i[6:0];
  assign rd_idx  = instr_i[11:7];
  assign funct3  = instr_i[14:12];
  assign rs1_idx = instr_i[19:15];
  assign rs2_idx = instr_i[24:20];
  assign funct7  = instr_i[31:25];

  always_comb begin
    instr_d           = '0;
    instr_d.rd        = rd_idx;
    instr_d.alu_op    = ALU_ADD;
    instr_d.writes_rd = 1'b1;
    uses_rs1          = 1'b0;
    uses_rs2          = 1'b0;
    bad_enc           = 1'b0;
    case (opcode)
      OPC_OP: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        // Only SUB and SRA take the alternate funct7
        if (funct7 == F7_ALT) begin
          bad_enc = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          bad_enc = (funct7 != F7_BASE);
        end
      end
      OPC_OP_IMM: begin
        uses_rs1        = 1'b1;
        instr_d.use_imm = 1'b1;
        instr_d.imm     = {{20{instr_i[31]}}, instr_i[31:20]};
        // Shift immediates reuse funct7 as a mode field
        if (funct3 == 3'b001) bad_enc = (funct7 != F7_BASE);
        if (funct3 == 3'b101) bad_enc = (funct7 != F7_BASE) && (funct7 != F7_ALT);
      end
      OPC_LUI: begin
        instr_d.use_imm = 1'b1;
        instr_d.imm     = {instr_i[31:12], 12'b0};
      end
      default: bad_enc = 1'b1;
    endcase

    // Operation from funct3, alternate funct7 picks SUB or SRA
    case (funct3)
      3'b000:  instr_d.alu_op = (uses_rs2 && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
      3'b001:  instr_d.alu_op = ALU_SLL;
      3'b010:  instr_d.alu_op = ALU_SLT;
      3'b011:  instr_d.alu_op = ALU_SLTU;
      3'b100:  instr_d.alu_op = ALU_XOR;
      3'b101:  instr_d.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
      3'b110:  instr_d.alu_op = ALU_OR;
      default: instr_d.alu_op = ALU_AND;
    endcase
    if (opcode == OPC_LUI) instr_d.alu_op = ALU_PASSB;

    // Unused source indices read x0 so they never hit the bypass
    instr_d.rs1 = uses_rs1 ? rs1_idx : '0;
    instr_d.rs2 = uses_rs2 ? rs2_idx : '0;

    // RV32E has only x0..x15
    bad_idx = RV32E && (instr_d.rd[4] || instr_d.rs1[4] || instr_d.rs2[4]);
    illegal = bad_enc || bad_idx;
    instr_d.writes_rd = !illegal;
  end

  assign dec_o.instr   = instr_d;
  assign dec_o.valid   = instr_valid_i && !illegal;
  assign dec_o.illegal = instr_valid_i && illegal;

  // A strobed instruction word must be fully known
  always_comb begin
    a_known_instr: assert (!(instr_valid_i === 1'b1 && $isunknown(instr_i)))
      else $error("Decoder received an instruction word with unknown bits");
  end

endmodule

`default_nettype wire

// File: rv_alu.sv
/*
  RV32I integer ALU
  Add, subtract, logic, shifts, set-less-than and operand B pass-through
*/
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  logic [rv_core_pkg::XLEN-1:0] operand_a_i,
  input  logic [rv_core_pkg::XLEN-1:0] operand_b_i,
  input  rv_core_pkg::alu_op_e         alu_op_i,
  output logic [rv_core_pkg::XLEN-1:0] result_o
);
  import rv_core_pkg::*;

  // Shift amount is the low five bits of B, immediate or register
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = operand_b_i[4:0];
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:   result_o = operand_a_i + operand_b_i;
      ALU_SUB:   result_o = operand_a_i - operand_b_i;
      ALU_AND:   result_o = operand_a_i & operand_b_i;
      ALU_OR:    result_o = operand_a_i | operand_b_i;
      ALU_XOR:   result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:   result_o = operand_a_i << shamt;
      ALU_SRL:   result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA:   result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Compare results are zero-extended flags
      ALU_SLT:   result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:  result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      // LUI, immediate already shifted by the decoder
      ALU_PASSB: result_o = operand_b_i;
      default:   result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rv_writeback.sv
/*
  Writeback stage and operand bypass
  Holds each result one cycle, writes the register file, forwards to the next
*/
`timescale 1ns/1ps
`default_nettype none

module rv_writeback (
  input  logic                               clk_i,
  input  logic                               reset_i,
  rv_dec_if.exe                              dec_i,
  input  logic [rv_core_pkg::XLEN-1:0]       rdata_a_i,
  input  logic [rv_core_pkg::XLEN-1:0]       rdata_b_i,
  input  logic [rv_core_pkg::XLEN-1:0]       result_i,
  output logic [rv_core_pkg::XLEN-1:0]       operand_a_o,
  output logic [rv_core_pkg::XLEN-1:0]       operand_b_o,
  output logic                               rf_we_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [rv_core_pkg::XLEN-1:0]       rf_wdata_o,
  output logic                               wb_valid_o,
  output logic                               illegal_o
);
  import rv_core_pkg::*;

  logic                  pend_valid_q;
  logic                  illegal_q;
  logic [REG_ADDR_W-1:0] pend_rd_q;
  logic [XLEN-1:0]       pend_data_q;
  logic                  hit_a;
  logic                  hit_b;

  // Pending result matches a source, x0 is excluded through rf_we_o
  assign hit_a = rf_we_o && (pend_rd_q == dec_i.instr.rs1);
  assign hit_b = rf_we_o && (pend_rd_q == dec_i.instr.rs2);

  assign operand_a_o = hit_a ? pend_data_q : rdata_a_i;
  assign operand_b_o = dec_i.instr.use_imm ? dec_i.instr.imm :
                       hit_b               ? pend_data_q     : rdata_b_i;

  // Control flops
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_valid_q <= 1'b0;
      illegal_q    <= 1'b0;
    end else begin
      pend_valid_q <= dec_i.valid && dec_i.instr.writes_rd;
      illegal_q    <= dec_i.illegal;
    end
  end

  // Payload, a write to x0 reports zero
  always_ff @(posedge clk_i) begin
    pend_rd_q   <= dec_i.instr.rd;
    pend_data_q <= (dec_i.instr.rd == '0) ? '0 : result_i;
  end

  assign rf_we_o    = pend_valid_q && (pend_rd_q != '0);
  assign rf_waddr_o = pend_rd_q;
  assign rf_wdata_o = pend_data_q;
  assign wb_valid_o = pend_valid_q;
  assign illegal_o  = illegal_q;

  // An instruction is either written back or rejected, never both
  a_wb_or_illegal: assert property (@(posedge clk_i) disable iff (reset_i)
    !(pend_valid_q && illegal_q))
    else $error("Writeback valid and illegal flag raised together");

endmodule

`default_nettype wire

// File: rv_exec_top.sv
/*
  RV32I execution subsystem top
  Decoder, register file, ALU and writeback with one-cycle result latency
*/
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top #(
  parameter bit                              RV32E       = 1'b0,
  parameter logic [rv_core_pkg::XLEN-1:0]    WordZeroVal = '0
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               instr_valid_i,
  input  logic [rv_core_pkg::XLEN-1:0]       instr_i,
  output logic                               wb_valid_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [rv_core_pkg::XLEN-1:0]       wb_data_o,
  output logic                               illegal_o
);
  import rv_core_pkg::*;

  logic [XLEN-1:0]       rdata_a;
  logic [XLEN-1:0]       rdata_b;
  logic [XLEN-1:0]       operand_a;
  logic [XLEN-1:0]       operand_b;
  logic [XLEN-1:0]       alu_result;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;

  rv_dec_if dec_if ();

  rv_decoder #(.RV32E(RV32E)) u_decoder (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .dec_o         (dec_if)
  );

  rv_regfile_fpga #(.RV32E(RV32E), .WordZeroVal(WordZeroVal)) u_regfile (
    .clk_i     (clk_i),
    .raddr_a_i (dec_if.instr.rs1),
    .raddr_b_i (dec_if.instr.rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we)
  );

  rv_alu u_alu (
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .alu_op_i    (dec_if.instr.alu_op),
    .result_o    (alu_result)
  );

  rv_writeback u_writeback (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .dec_i       (dec_if),
    .rdata_a_i   (rdata_a),
    .rdata_b_i   (rdata_b),
    .result_i    (alu_result),
    .operand_a_o (operand_a),
    .operand_b_o (operand_b),
    .rf_we_o     (rf_we),
    .rf_waddr_o  (rf_waddr),
    .rf_wdata_o  (rf_wdata),
    .wb_valid_o  (wb_valid_o),
    .illegal_o   (illegal_o)
  );

  // Result reported in the cycle it waits for the register file
  assign wb_rd_o   = rf_waddr;
  assign wb_data_o = rf_wdata;

endmodule

`default_nettype wire

// File: tb_rv_exec.sv
/*
  Testbench for the RV32I execution subsystem
  Random OP, OP-IMM, LUI and illegal words against a register-level model
*/
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec;

  localparam logic [31:0] SEED       = 32'hfb54_fa0c;
  localparam int          NUM_ISSUES = 3000;

  // Expected outcome of one cycle at the writeback outputs
  typedef struct packed {
    logic        wb;
    logic        ill;
    logic [4:0]  rd;
    logic [31:0] data;
  } exp_t;

  logic        clk_i;
  logic        reset_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        wb_valid_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_data_o;
  logic        illegal_o;

  // Architectural state of the model, x0 never written
  logic [31:0] regs [32];
  exp_t        exp_q [$];
  logic [31:0] rng;
  int          n_pushed;
  int          n_checked;
  int          fail_count;

  rv_exec_top #(.RV32E(1'b0), .WordZeroVal(32'h0)) dut0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o),
    .illegal_o     (illegal_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Expected writeback of one instruction from the RV32I rules
  function automatic exp_t ref_execute(input logic [31:0] instr, input logic [31:0] a,
                                       input logic [31:0] rs2_val);
    exp_t        e;
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] b;
    logic [31:0] res;
    logic [4:0]  sh;
    logic        legal;
    logic        alt;
    opc   = instr[6:0];
    f3    = instr[14:12];
    f7    = instr[31:25];
    alt   = (f7 == 7'h20);
    b     = rs2_val;
    res   = 32'h0;
    legal = 1'b1;
    if (opc == 7'h33) begin
      legal = (f7 == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
    end else if (opc == 7'h13) begin
      b = {{20{instr[31]}}, instr[31:20]};
      if (f3 == 3'd1) legal = (f7 == 7'h00);
      if (f3 == 3'd5) legal = (f7 == 7'h00) || alt;
      // ADDI has no SUB form, upper bits are immediate
      if (f3 == 3'd0) alt = 1'b0;
    end else if (opc != 7'h37) begin
      legal = 1'b0;
    end
    sh = b[4:0];
    case (f3)
      3'd0: res = alt ? a - b : a + b;
      3'd1: res = a << sh;
      3'd2: res = {31'h0, $signed(a) < $signed(b)};
      3'd3: res = {31'h0, a < b};
      3'd4: res = a ^ b;
      // Logical shift, then refill the top with the sign for SRA
      3'd5: res = (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    if (opc == 7'h37) res = {instr[31:12], 12'h000};
    e.wb   = legal;
    e.ill  = !legal;
    e.rd   = legal ? instr[11:7] : 5'd0;
    // x0 reports zero
    e.data = (legal && instr[11:7] != 5'd0) ? res : 32'h0;
    return e;
  endfunction

  // One instruction word from two random words, low indices favoured for dependencies
  function automatic logic [31:0] build_instr(input logic [31:0] r, input logic [31:0] s);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    rd  = r[3] ? r[8:4] : {2'b00, r[6:4]};
    rs1 = r[9] ? r[14:10] : {2'b00, r[12:10]};
    rs2 = r[15] ? r[20:16] : {2'b00, r[18:16]};
    f3  = r[23:21];
    f7  = (r[24] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
    imm = s[11:0];
    if (f3 == 3'd1) imm[11:5] = 7'h00;
    if (f3 == 3'd5) imm[11:5] = f7;
    case (r[27:25])
      3'd0, 3'd1, 3'd2: return {f7, rs2, rs1, f3, rd, 7'h33};
      3'd3, 3'd4, 3'd5: return {imm, rs1, f3, rd, 7'h13};
      3'd6: return {s[31:12], rd, 7'h37};
      default: begin
        case (r[29:28])
          // Load opcode, not handled here
          2'd0: return {s[31:7], 7'h03};
          2'd1: return {7'h01, rs2, rs1, f3, rd, 7'h33};
          2'd2: return {7'h20, rs2, rs1, 3'd1, rd, 7'h33};
          // SLLI with the SRAI mode bit
          default: return {7'h20, s[24:20], rs1, 3'd1, rd, 7'h13};
        endcase
      end
    endcase
  endfunction

  task automatic fail_now(input string why);
    fail_count++;
    $display("%s", why);
    $display("test failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else fail_now($sformatf("Mismatch at %0t ns: %s expected 0x%08h, actual 0x%08h",
                              $time, name, expected, actual));
  endtask

  // Drive one cycle and record what the outputs must show a cycle later
  task automatic issue(input logic valid, input logic [31:0] instr);
    exp_t e;
    @(posedge clk_i);
    instr_valid_i <= valid;
    instr_i       <= instr;
    e = '0;
    if (valid) begin
      e = ref_execute(instr, regs[instr[19:15]], regs[instr[24:20]]);
      if (e.wb && e.rd != 5'd0) regs[e.rd] = e.data;
    end
    exp_q.push_back(e);
    n_pushed++;
  endtask

  // Compare process, outputs are settled at the falling edge
  initial begin
    exp_t cur;
    logic cur_from_q;
    int   wait_cycles;
    cur         = '0;
    cur_from_q  = 1'b0;
    n_checked   = 0;
    wait_cycles = 0;
    while (reset_i !== 1'b0) begin
      @(negedge clk_i);
      wait_cycles++;
      if (wait_cycles > 20) fail_now("Reset was never released");
    end
    forever begin
      @(negedge clk_i);
      check_value("wb_valid_o", {31'h0, cur.wb}, {31'h0, wb_valid_o});
      check_value("illegal_o", {31'h0, cur.ill}, {31'h0, illegal_o});
      if (cur.wb) begin
        check_value("wb_rd_o", {27'h0, cur.rd}, {27'h0, wb_rd_o});
        check_value("wb_data_o", cur.data, wb_data_o);
      end
      if (cur_from_q) n_checked++;
      // Entry pushed at the last rising edge becomes due at the next falling edge
      if (exp_q.size() > 0) begin
        cur        = exp_q.pop_front();
        cur_from_q = 1'b1;
      end else begin
        cur        = '0;
        cur_from_q = 1'b0;
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] s;
    int          wait_cycles;
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = 32'h0;
    rng           = SEED;
    n_pushed      = 0;
    fail_count    = 0;
    wait_cycles   = 0;
    for (int k = 0; k < 32; k++) begin
      regs[k] = 32'h0;
    end
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    // Quiet cycles, outputs must stay low
    repeat (4) @(posedge clk_i);
    for (int i = 0; i < NUM_ISSUES; i++) begin
      rng = xorshift32(rng);
      r   = rng;
      rng = xorshift32(rng);
      s   = rng;
      // About one cycle in four left empty
      issue(r[31:30] != 2'b00, build_instr(r, s));
    end
    issue(1'b0, 32'h0);
    while (n_checked < n_pushed) begin
      @(negedge clk_i);
      wait_cycles++;
      if (wait_cycles > 10) fail_now("Timed out waiting for the last writebacks");
    end
    if (fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
rv_core_pkg.sv
rv_dec_if.sv
rv_regfile_fpga.sv
rv_decoder.sv
rv_alu.sv
rv_writeback.sv
rv_exec_top.sv
tb_rv_exec.sv

// File: Makefile
# Verilator flow for the RV32I execution subsystem

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
TOP       ?= tb_rv_exec
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit status is not used
sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
